//--- common/afu_pkg.sv
// Shared address, page-table, payload and CSR definitions for the translation front end.
// RTL and testbench take these through a wildcard import of afu_pkg.

package afu_pkg;

    // ==================================================
    // Addresses and page numbers
    // ==================================================

    // Byte addresses on both sides of the translation are 48 bits
    typedef logic [47:0] t_va;
    typedef logic [47:0] t_pa;

    // 4 KB pages, so the low 12 bits pass through untranslated
    localparam int PAGE_BITS = 12;

    typedef logic [47-PAGE_BITS:0] t_vpn;
    typedef logic [47-PAGE_BITS:0] t_ppn;

    // One page-table entry, 73 bits with the valid flag on top
    typedef struct packed {
        logic valid;
        t_vpn vpn;
        t_ppn ppn;
    } t_pt_entry;

    // Width of an index into a table of n entries, never less than one bit
    function automatic int pt_idx_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // ==================================================
    // Request payloads and statistics
    // ==================================================

    typedef logic [7:0] t_rd_tag;

    typedef struct packed {
        logic [7:0] tag;
        logic [63:0] data;
    } t_wr_payload;

    // Failure counter, wraps at 2^16
    typedef logic [15:0] t_fail_cnt;

    // ==================================================
    // MMIO and CSR space
    // ==================================================

    typedef logic [63:0] t_csr_data;
    // Quad-word index, the byte address without its low bits
    typedef logic [9:0] t_csr_idx;
    typedef logic [8:0] t_mmio_tid;

    localparam logic [127:0] TEST_ID = 128'h3e51a0c2_8d47_4b6f_a913_5c07e2d4f186;

    localparam t_csr_idx CSR_ID_LO      = 10'd0;
    localparam t_csr_idx CSR_ID_HI      = 10'd1;
    localparam t_csr_idx CSR_PT_SIZE    = 10'd2;
    localparam t_csr_idx CSR_RD_FAIL_VA = 10'd3;
    localparam t_csr_idx CSR_WR_FAIL_VA = 10'd4;
    localparam t_csr_idx CSR_FAIL_CNT   = 10'd5;
    // Page-table window, two words per entry
    localparam t_csr_idx CSR_PT_BASE    = 10'd16;

endpackage

//--- xlate/page_table.sv
// Fully associative VPN to PPN table shared by the read and write channels.
// One registered write port from the CSR block, two combinational lookup ports.

`timescale 1ns/100ps

module page_table
    import afu_pkg::*;
#(
    parameter int NUM_PT_ENTRIES = 8
)
(
    input  logic clk,
    input  logic rst,

    input  logic pt_wr_en,
    input  logic [pt_idx_width(NUM_PT_ENTRIES)-1:0] pt_wr_idx,
    input  t_pt_entry pt_wr_entry,

    input  t_vpn rd_lookup_vpn,
    output logic rd_lookup_hit,
    output t_ppn rd_lookup_ppn,

    input  t_vpn wr_lookup_vpn,
    output logic wr_lookup_hit,
    output t_ppn wr_lookup_ppn
);

    // One valid flag, one VPN and one PPN per entry
    logic [NUM_PT_ENTRIES-1:0] ent_valid;
    t_vpn ent_vpn [NUM_PT_ENTRIES];
    t_ppn ent_ppn [NUM_PT_ENTRIES];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ent_valid <= '0;
        end
        else if (pt_wr_en)
        begin
            ent_valid[pt_wr_idx] <= pt_wr_entry.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pt_wr_en)
        begin
            ent_vpn[pt_wr_idx] <= pt_wr_entry.vpn;
            ent_ppn[pt_wr_idx] <= pt_wr_entry.ppn;
        end
    end

    // Compare against every valid entry; scanning downward leaves the lowest match
    function automatic logic [$bits(t_ppn):0] find_entry(input t_vpn vpn);
        logic [$bits(t_ppn):0] result;
        result = '0;
        for (int i = NUM_PT_ENTRIES - 1; i >= 0; i--)
        begin
            if (ent_valid[i] && (ent_vpn[i] == vpn))
            begin
                result = {1'b1, ent_ppn[i]};
            end
        end
        return result;
    endfunction

    // Both ports see the table as it was before any write in the same cycle
    always_comb
    begin
        {rd_lookup_hit, rd_lookup_ppn} = find_entry(rd_lookup_vpn);
        {wr_lookup_hit, wr_lookup_ppn} = find_entry(wr_lookup_vpn);
    end

endmodule

//--- xlate/xlate_channel.sv
// One translation channel: looks up the request page, then either forwards the
// physical request one cycle later or records the miss and drops the request.
// Instantiated once for reads and once for writes with different payload types.

`timescale 1ns/100ps

module xlate_channel
    import afu_pkg::*;
#(
    parameter type payload_t = t_rd_tag
)
(
    input  logic clk,
    input  logic rst,

    // Virtual request, a single-cycle strobe with no back-pressure
    input  logic in_valid,
    input  t_va in_va,
    input  payload_t in_payload,

    // Page-table lookup port
    output t_vpn lookup_vpn,
    input  logic lookup_hit,
    input  t_ppn lookup_ppn,

    // Translated request
    output logic out_valid,
    output t_pa out_pa,
    output payload_t out_payload,

    // Failure statistics for the CSR block
    output t_va fail_va,
    output t_fail_cnt fail_cnt
);

    logic req_miss;

    // ==================================================
    // Lookup stage
    // ==================================================

    // Page number goes to the table straight from the input, no register in between
    assign lookup_vpn = in_va[$bits(t_va)-1:PAGE_BITS];

    // A strobe that finds no valid mapping takes the failure path
    assign req_miss = in_valid && !lookup_hit;

    // ==================================================
    // Register stage, success side of the fork
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            // Only hits come out, misses leave no trace on this side
            out_valid <= in_valid && lookup_hit;
        end
    end

    // Address and payload are captured every cycle and qualified by out_valid
    always_ff @(posedge clk)
    begin
        out_pa <= {lookup_ppn, in_va[PAGE_BITS-1:0]};
        out_payload <= in_payload;
    end

    // ==================================================
    // Failure side of the fork
    // ==================================================

    // The request itself is dropped here
    // Software sees only the last failed VA and a running count
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fail_va <= '0;
            fail_cnt <= '0;
        end
        else if (req_miss)
        begin
            fail_va <= in_va;
            // Counter rolls over at 2^16
            fail_cnt <= fail_cnt + 1'b1;
        end
    end

endmodule

//--- hdl/csr_mgr.sv
// MMIO CSR manager: turns pairs of page-table CSR writes into table updates and
// answers global CSR reads one cycle after the request, echoing the read tag.

`timescale 1ns/100ps

module csr_mgr
    import afu_pkg::*;
#(
    parameter int NUM_PT_ENTRIES = 8
)
(
    input  logic clk,
    input  logic rst,

    // MMIO write side
    input  logic wr_write,
    input  t_csr_idx wr_address,
    input  t_csr_data wr_writedata,

    // MMIO read side
    input  logic rd_read,
    input  t_csr_idx rd_address,
    input  t_mmio_tid rd_tid_in,
    output logic rd_readdatavalid,
    output t_csr_data rd_readdata,
    output t_mmio_tid rd_tid_out,

    // Page-table write port
    output logic pt_wr_en,
    output logic [pt_idx_width(NUM_PT_ENTRIES)-1:0] pt_wr_idx,
    output t_pt_entry pt_wr_entry,

    // Failure statistics from the two channels
    input  t_va rd_fail_va,
    input  t_fail_cnt rd_fail_cnt,
    input  t_va wr_fail_va,
    input  t_fail_cnt wr_fail_cnt
);

    localparam int PT_IDX_W = pt_idx_width(NUM_PT_ENTRIES);
    // Two quad words per entry, VPN first and then valid plus PPN
    localparam int PT_SPAN = 2 * NUM_PT_ENTRIES;

    logic in_pt_window;
    t_csr_idx pt_off;
    t_vpn pend_vpn;
    t_csr_data rd_mux;

    // ==================================================
    // Page-table writes
    // ==================================================

    assign pt_off = wr_address - CSR_PT_BASE;
    assign in_pt_window = (int'(wr_address) >= int'(CSR_PT_BASE)) &&
                          (int'(wr_address) < int'(CSR_PT_BASE) + PT_SPAN);

    // Even word of a pair only stages the VPN, nothing is committed yet
    always_ff @(posedge clk)
    begin
        if (wr_write && in_pt_window && !pt_off[0])
        begin
            pend_vpn <= wr_writedata[$bits(t_vpn)-1:0];
        end
    end

    // Odd word commits the whole entry on the following cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pt_wr_en <= 1'b0;
        end
        else
        begin
            pt_wr_en <= wr_write && in_pt_window && pt_off[0];
        end
    end

    always_ff @(posedge clk)
    begin
        pt_wr_idx <= pt_off[PT_IDX_W:1];
        // Bit 63 is the valid flag, bits 62:36 are ignored
        pt_wr_entry.valid <= wr_writedata[63];
        pt_wr_entry.vpn <= pend_vpn;
        pt_wr_entry.ppn <= wr_writedata[$bits(t_ppn)-1:0];
    end

    // ==================================================
    // Global CSR reads
    // ==================================================

    always_comb
    begin
        case (rd_address)
            CSR_ID_LO:      rd_mux = TEST_ID[63:0];
            CSR_ID_HI:      rd_mux = TEST_ID[127:64];
            CSR_PT_SIZE:    rd_mux = t_csr_data'(NUM_PT_ENTRIES);
            CSR_RD_FAIL_VA: rd_mux = t_csr_data'(rd_fail_va);
            CSR_WR_FAIL_VA: rd_mux = t_csr_data'(wr_fail_va);
            // Write count above read count, upper half reads zero
            CSR_FAIL_CNT:   rd_mux = {32'd0, wr_fail_cnt, rd_fail_cnt};
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_readdatavalid <= 1'b0;
        end
        else
        begin
            rd_readdatavalid <= rd_read;
        end
    end

    // Data and tag ride along with the valid, one cycle after the read
    always_ff @(posedge clk)
    begin
        rd_readdata <= rd_mux;
        rd_tid_out <= rd_tid_in;
    end

endmodule

//--- hdl/afu_top.sv
// Top level of the translation front end: page table, read and write channels
// and the CSR manager. Set NUM_PT_ENTRIES here; it is passed to the table and CSRs.

`timescale 1ns/100ps

module afu_top
    import afu_pkg::*;
#(
    parameter int NUM_PT_ENTRIES = 8
)
(
    input  logic clk,
    input  logic rst,

    // MMIO
    input  logic wr_write,
    input  t_csr_idx wr_address,
    input  t_csr_data wr_writedata,
    input  logic rd_read,
    input  t_csr_idx rd_address,
    input  t_mmio_tid rd_tid_in,
    output logic rd_readdatavalid,
    output t_csr_data rd_readdata,
    output t_mmio_tid rd_tid_out,

    // Virtual requests
    input  logic rd_req_valid,
    input  t_va rd_req_va,
    input  t_rd_tag rd_req_tag,
    input  logic wr_req_valid,
    input  t_va wr_req_va,
    input  t_wr_payload wr_req_payload,

    // Translated requests
    output logic rd_out_valid,
    output t_pa rd_out_pa,
    output t_rd_tag rd_out_tag,
    output logic wr_out_valid,
    output t_pa wr_out_pa,
    output t_wr_payload wr_out_payload
);

    logic pt_wr_en;
    logic [pt_idx_width(NUM_PT_ENTRIES)-1:0] pt_wr_idx;
    t_pt_entry pt_wr_entry;

    t_vpn rd_lookup_vpn;
    logic rd_lookup_hit;
    t_ppn rd_lookup_ppn;
    t_vpn wr_lookup_vpn;
    logic wr_lookup_hit;
    t_ppn wr_lookup_ppn;

    t_va rd_fail_va;
    t_fail_cnt rd_fail_cnt;
    t_va wr_fail_va;
    t_fail_cnt wr_fail_cnt;

    // ==================================================
    // Shared page table
    // ==================================================

    page_table #(
        .NUM_PT_ENTRIES(NUM_PT_ENTRIES)
    ) pt (
        .clk(clk),
        .rst(rst),
        .pt_wr_en(pt_wr_en),
        .pt_wr_idx(pt_wr_idx),
        .pt_wr_entry(pt_wr_entry),
        .rd_lookup_vpn(rd_lookup_vpn),
        .rd_lookup_hit(rd_lookup_hit),
        .rd_lookup_ppn(rd_lookup_ppn),
        .wr_lookup_vpn(wr_lookup_vpn),
        .wr_lookup_hit(wr_lookup_hit),
        .wr_lookup_ppn(wr_lookup_ppn)
    );

    // ==================================================
    // Translation channels
    // ==================================================

    xlate_channel #(
        .payload_t(t_rd_tag)
    ) rd_chan (
        .clk(clk),
        .rst(rst),
        .in_valid(rd_req_valid),
        .in_va(rd_req_va),
        .in_payload(rd_req_tag),
        .lookup_vpn(rd_lookup_vpn),
        .lookup_hit(rd_lookup_hit),
        .lookup_ppn(rd_lookup_ppn),
        .out_valid(rd_out_valid),
        .out_pa(rd_out_pa),
        .out_payload(rd_out_tag),
        .fail_va(rd_fail_va),
        .fail_cnt(rd_fail_cnt)
    );

    // Write channel carries tag and data through untouched
    xlate_channel #(
        .payload_t(t_wr_payload)
    ) wr_chan (
        .clk(clk),
        .rst(rst),
        .in_valid(wr_req_valid),
        .in_va(wr_req_va),
        .in_payload(wr_req_payload),
        .lookup_vpn(wr_lookup_vpn),
        .lookup_hit(wr_lookup_hit),
        .lookup_ppn(wr_lookup_ppn),
        .out_valid(wr_out_valid),
        .out_pa(wr_out_pa),
        .out_payload(wr_out_payload),
        .fail_va(wr_fail_va),
        .fail_cnt(wr_fail_cnt)
    );

    // ==================================================
    // CSR manager
    // ==================================================

    csr_mgr #(
        .NUM_PT_ENTRIES(NUM_PT_ENTRIES)
    ) csrs (
        .clk(clk),
        .rst(rst),
        .wr_write(wr_write),
        .wr_address(wr_address),
        .wr_writedata(wr_writedata),
        .rd_read(rd_read),
        .rd_address(rd_address),
        .rd_tid_in(rd_tid_in),
        .rd_readdatavalid(rd_readdatavalid),
        .rd_readdata(rd_readdata),
        .rd_tid_out(rd_tid_out),
        .pt_wr_en(pt_wr_en),
        .pt_wr_idx(pt_wr_idx),
        .pt_wr_entry(pt_wr_entry),
        .rd_fail_va(rd_fail_va),
        .rd_fail_cnt(rd_fail_cnt),
        .wr_fail_va(wr_fail_va),
        .wr_fail_cnt(wr_fail_cnt)
    );

endmodule

//--- test/afu_sva.sv
// Concurrent timing rules on the request, translation and CSR strobes.
// Bound into every afu_top instance.

`timescale 1ns/100ps

module afu_sva
(
    input logic clk,
    input logic rst,
    input logic rd_req_valid,
    input logic wr_req_valid,
    input logic rd_read,
    input logic rd_out_valid,
    input logic wr_out_valid,
    input logic rd_readdatavalid
);

    // A translated request always stems from a request one cycle earlier
    rd_out_from_req: assert property (@(posedge clk) disable iff (rst)
        rd_out_valid |-> $past(rd_req_valid))
        else $error("rd_out_valid without a read request one cycle earlier");

    wr_out_from_req: assert property (@(posedge clk) disable iff (rst)
        wr_out_valid |-> $past(wr_req_valid))
        else $error("wr_out_valid without a write request one cycle earlier");

    // CSR read data returns exactly one cycle after the read strobe
    csr_rd_latency: assert property (@(posedge clk) disable iff (rst)
        rd_readdatavalid |-> $past(rd_read))
        else $error("rd_readdatavalid without rd_read one cycle earlier");

    // Every output strobe is quiet in the cycle after reset
    quiet_after_rst: assert property (@(posedge clk)
        $past(rst) |-> (!rd_out_valid && !wr_out_valid && !rd_readdatavalid))
        else $error("Output strobe high in the cycle after reset");

endmodule

bind afu_top afu_sva sva (.*);

//--- test/afu_tb.sv
// Self-checking testbench for afu_top: CSR reset values, page-table programming,
// read and write translation, miss statistics and a long random mixed stream.

`timescale 1ns/100ps

module afu_tb
    import afu_pkg::*;
();

    localparam int NUM_PT = 8;
    localparam int WAIT_LIMIT = 16;
    localparam t_vpn VPN_BASE = 36'h0_3a21_0400;
    localparam t_ppn PPN_BASE = 36'h7_1c00_0000;

    logic clk = 1'b0;
    logic rst;
    logic wr_write;
    t_csr_idx wr_address;
    t_csr_data wr_writedata;
    logic rd_read;
    t_csr_idx rd_address;
    t_mmio_tid rd_tid_in;
    logic rd_readdatavalid;
    t_csr_data rd_readdata;
    t_mmio_tid rd_tid_out;
    logic rd_req_valid;
    t_va rd_req_va;
    t_rd_tag rd_req_tag;
    logic wr_req_valid;
    t_va wr_req_va;
    t_wr_payload wr_req_payload;
    logic rd_out_valid;
    t_pa rd_out_pa;
    t_rd_tag rd_out_tag;
    logic wr_out_valid;
    t_pa wr_out_pa;
    t_wr_payload wr_out_payload;

    integer seed = 32'he628_3bba;
    string test_name = "reset";
    t_mmio_tid tid_ctr = '0;

    // Model page table plus the entry that commits at the next clock edge
    logic mdl_valid [NUM_PT];
    t_vpn mdl_vpn [NUM_PT];
    t_ppn mdl_ppn [NUM_PT];
    t_vpn mdl_pend_vpn;
    logic upd_pending = 1'b0;
    int upd_idx;
    logic upd_valid;
    t_vpn upd_vpn;
    t_ppn upd_ppn;
    int rd_miss_total = 0;
    int wr_miss_total = 0;
    t_va mdl_rd_fail_va = '0;
    t_va mdl_wr_fail_va = '0;

    // Expected outputs for the cycle after the one just sampled
    logic exp_ready = 1'b0;
    logic exp_rd_valid;
    t_pa exp_rd_pa;
    t_rd_tag exp_rd_tag;
    logic exp_wr_valid;
    t_pa exp_wr_pa;
    t_wr_payload exp_wr_payload;
    logic exp_csr_valid;
    t_csr_data exp_csr_data;
    t_mmio_tid exp_tid;

    afu_top #(
        .NUM_PT_ENTRIES(NUM_PT)
    ) uut (
        .*
    );

    always #4 clk = ~clk;

    // ==================================================
    // Reference model
    // ==================================================

    // Scan upward from entry 0 and stop at the first valid match
    function automatic logic [48:0] ref_xlate(input t_va va);
        logic [48:0] res;
        res = '0;
        for (int i = 0; i < NUM_PT; i++)
        begin
            if (!res[48] && mdl_valid[i] && (mdl_vpn[i] == va[47:12]))
            begin
                res = {1'b1, mdl_ppn[i], va[11:0]};
            end
        end
        return res;
    endfunction

    function automatic t_csr_data ref_csr(input t_csr_idx idx);
        case (idx)
            CSR_ID_LO:      return TEST_ID[63:0];
            CSR_ID_HI:      return TEST_ID[127:64];
            CSR_PT_SIZE:    return 64'(NUM_PT);
            CSR_RD_FAIL_VA: return {16'd0, mdl_rd_fail_va};
            CSR_WR_FAIL_VA: return {16'd0, mdl_wr_fail_va};
            CSR_FAIL_CNT:   return {32'd0, t_fail_cnt'(wr_miss_total), t_fail_cnt'(rd_miss_total)};
            default:        return '0;
        endcase
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic report_fail();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout in test %s while waiting for %s", test_name, what);
        report_fail();
    endtask

    task automatic check_valid(input string what, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            report_fail();
        end
    endtask

    task automatic check_pa(input string what, input t_pa exp, input t_pa act);
        if (exp !== act)
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            report_fail();
        end
    endtask

    task automatic check_rd_tag(input string what, input t_rd_tag exp, input t_rd_tag act);
        if (exp !== act)
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            report_fail();
        end
    endtask

    task automatic check_wr_payload(input string what, input t_wr_payload exp,
                                    input t_wr_payload act);
        if (exp !== act)
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            report_fail();
        end
    endtask

    task automatic check_csr(input string what, input t_csr_data exp, input t_csr_data act);
        if (exp !== act)
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            report_fail();
        end
    endtask

    task automatic check_tid(input string what, input t_mmio_tid exp, input t_mmio_tid act);
        if (exp !== act)
        begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            report_fail();
        end
    endtask

    // ==================================================
    // Compare process
    // ==================================================

    // Runs on the falling edge, where inputs and outputs are both settled
    always @(negedge clk)
    begin : compare
        logic [48:0] rd_res;
        logic [48:0] wr_res;
        t_csr_idx pt_off;
        if (exp_ready)
        begin
            check_valid("rd_out_valid", exp_rd_valid, rd_out_valid);
            if (exp_rd_valid)
            begin
                check_pa("rd_out_pa", exp_rd_pa, rd_out_pa);
                check_rd_tag("rd_out_tag", exp_rd_tag, rd_out_tag);
            end
            check_valid("wr_out_valid", exp_wr_valid, wr_out_valid);
            if (exp_wr_valid)
            begin
                check_pa("wr_out_pa", exp_wr_pa, wr_out_pa);
                check_wr_payload("wr_out_payload", exp_wr_payload, wr_out_payload);
            end
            check_valid("rd_readdatavalid", exp_csr_valid, rd_readdatavalid);
            if (exp_csr_valid)
            begin
                check_csr("rd_readdata", exp_csr_data, rd_readdata);
                check_tid("rd_tid_out", exp_tid, rd_tid_out);
            end
        end
        // CSR reads see the statistics from before this cycle's misses
        exp_csr_valid = !rst && rd_read;
        exp_csr_data = ref_csr(rd_address);
        exp_tid = rd_tid_in;
        rd_res = ref_xlate(rd_req_va);
        wr_res = ref_xlate(wr_req_va);
        exp_rd_valid = !rst && rd_req_valid && rd_res[48];
        exp_rd_pa = rd_res[47:0];
        exp_rd_tag = rd_req_tag;
        exp_wr_valid = !rst && wr_req_valid && wr_res[48];
        exp_wr_pa = wr_res[47:0];
        exp_wr_payload = wr_req_payload;
        if (!rst && rd_req_valid && !rd_res[48])
        begin
            rd_miss_total++;
            mdl_rd_fail_va = rd_req_va;
        end
        if (!rst && wr_req_valid && !wr_res[48])
        begin
            wr_miss_total++;
            mdl_wr_fail_va = wr_req_va;
        end
        // Odd word seen one edge ago lands in the table at the coming edge
        if (upd_pending)
        begin
            mdl_valid[upd_idx] = upd_valid;
            mdl_vpn[upd_idx] = upd_vpn;
            mdl_ppn[upd_idx] = upd_ppn;
        end
        upd_pending = 1'b0;
        if (!rst && wr_write && (wr_address >= CSR_PT_BASE) &&
            (wr_address < CSR_PT_BASE + 2 * NUM_PT))
        begin
            pt_off = wr_address - CSR_PT_BASE;
            if (!pt_off[0])
            begin
                mdl_pend_vpn = wr_writedata[35:0];
            end
            else
            begin
                upd_pending = 1'b1;
                upd_idx = int'(pt_off >> 1);
                upd_valid = wr_writedata[63];
                upd_vpn = mdl_pend_vpn;
                upd_ppn = wr_writedata[35:0];
            end
        end
        exp_ready = 1'b1;
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Advance one clock and drop every strobe unless the caller raises it again
    task automatic next_cycle();
        @(posedge clk);
        wr_write <= 1'b0;
        rd_read <= 1'b0;
        rd_req_valid <= 1'b0;
        wr_req_valid <= 1'b0;
    endtask

    task automatic put_csr_write(input t_csr_idx idx, input t_csr_data data);
        wr_write <= 1'b1;
        wr_address <= idx;
        wr_writedata <= data;
    endtask

    task automatic put_csr_read(input t_csr_idx idx);
        rd_read <= 1'b1;
        rd_address <= idx;
        rd_tid_in <= tid_ctr;
        tid_ctr++;
    endtask

    task automatic put_rd_req(input t_va va, input t_rd_tag tag);
        rd_req_valid <= 1'b1;
        rd_req_va <= va;
        rd_req_tag <= tag;
    endtask

    task automatic put_wr_req(input t_va va, input t_wr_payload payload);
        wr_req_valid <= 1'b1;
        wr_req_va <= va;
        wr_req_payload <= payload;
    endtask

    // Two CSR writes per entry, page number first
    task automatic map_entry(input int idx, input t_vpn vpn, input t_ppn ppn, input logic valid);
        next_cycle();
        put_csr_write(t_csr_idx'(CSR_PT_BASE + 2 * idx), t_csr_data'(vpn));
        next_cycle();
        put_csr_write(t_csr_idx'(CSR_PT_BASE + 2 * idx + 1), {valid, 27'd0, ppn});
    endtask

    function automatic logic strobe_seen(input int sel);
        case (sel)
            0:       return rd_out_valid;
            1:       return wr_out_valid;
            default: return rd_readdatavalid;
        endcase
    endfunction

    task automatic wait_output(input int sel, input string what);
        int n;
        n = 0;
        do
        begin
            next_cycle();
            @(negedge clk);
            n++;
        end
        while (!strobe_seen(sel) && n < WAIT_LIMIT);
        if (!strobe_seen(sel))
        begin
            timeout_fail(what);
        end
    endtask

    task automatic read_csr_wait(input t_csr_idx idx);
        next_cycle();
        put_csr_read(idx);
        wait_output(2, "rd_readdatavalid");
    endtask

    // Sixteen candidate pages around VPN_BASE, so roughly half the stream misses
    function automatic t_va rand_va();
        int r;
        r = $random(seed);
        return {VPN_BASE + t_vpn'(r[3:0]), r[15:4]};
    endfunction

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        int r;
        int pair_idx;
        logic pair_open;
        rst = 1'b1;
        wr_write = 1'b0;
        wr_address = '0;
        wr_writedata = '0;
        rd_read = 1'b0;
        rd_address = '0;
        rd_tid_in = '0;
        rd_req_valid = 1'b0;
        rd_req_va = '0;
        rd_req_tag = '0;
        wr_req_valid = 1'b0;
        wr_req_va = '0;
        wr_req_payload = '0;
        for (int i = 0; i < NUM_PT; i++)
        begin
            mdl_valid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset_csrs";
        for (int i = 0; i <= 5; i++)
        begin
            read_csr_wait(t_csr_idx'(i));
        end

        test_name = "program_table";
        for (int i = 0; i < 4; i++)
        begin
            map_entry(i, VPN_BASE + t_vpn'(i), PPN_BASE + t_ppn'(16 * i + 5), 1'b1);
        end
        repeat (3) next_cycle();

        test_name = "rd_hit";
        next_cycle();
        put_rd_req({VPN_BASE + t_vpn'(2), 12'h5a8}, 8'h3c);
        wait_output(0, "rd_out_valid");

        test_name = "wr_hit";
        next_cycle();
        put_wr_req({VPN_BASE + t_vpn'(1), 12'hff0}, '{tag: 8'ha7, data: 64'h0123_4567_89ab_cdef});
        wait_output(1, "wr_out_valid");

        // Page VPN_BASE+9 is never mapped in this phase
        test_name = "miss_stats";
        next_cycle();
        put_rd_req({VPN_BASE + t_vpn'(9), 12'h010}, 8'h11);
        next_cycle();
        put_wr_req({VPN_BASE + t_vpn'(9), 12'h024}, '{tag: 8'h22, data: 64'd7});
        repeat (2) next_cycle();
        read_csr_wait(CSR_RD_FAIL_VA);
        read_csr_wait(CSR_WR_FAIL_VA);
        read_csr_wait(CSR_FAIL_CNT);

        // Mixed stream with entry remaps and invalidations in flight
        test_name = "random_stream";
        pair_open = 1'b0;
        pair_idx = 0;
        for (int c = 0; c < 400; c++)
        begin
            next_cycle();
            r = $random(seed);
            if (r[0])
            begin
                put_rd_req(rand_va(), r[15:8]);
            end
            if (r[1])
            begin
                put_wr_req(rand_va(), '{tag: r[23:16], data: {$random(seed), $random(seed)}});
            end
            if (pair_open)
            begin
                put_csr_write(t_csr_idx'(CSR_PT_BASE + 2 * pair_idx + 1),
                              {r[4:2] != 3'd0, 27'd0, t_ppn'({$random(seed), $random(seed)})});
                pair_open = 1'b0;
            end
            else if (r[7:5] == 3'd0)
            begin
                pair_idx = $random(seed) & 7;
                put_csr_write(t_csr_idx'(CSR_PT_BASE + 2 * pair_idx),
                              t_csr_data'(VPN_BASE + t_vpn'(r[11:8])));
                pair_open = 1'b1;
            end
            if (r[27:24] == 4'd0)
            begin
                put_csr_read(t_csr_idx'(r[30:28]));
            end
        end
        repeat (3) next_cycle();

        test_name = "final_stats";
        read_csr_wait(CSR_FAIL_CNT);
        read_csr_wait(CSR_RD_FAIL_VA);
        read_csr_wait(CSR_WR_FAIL_VA);
        repeat (2) next_cycle();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- sources.f
common/afu_pkg.sv
xlate/page_table.sv
xlate/xlate_channel.sv
hdl/csr_mgr.sv
hdl/afu_top.sv
test/afu_sva.sv
test/afu_tb.sv
